// File: execute.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module execute (
    input  mips_pkg::id_ex_t      i_id_ex,
    input  mips_pkg::fwd_sel_e    i_fwd_a,
    input  mips_pkg::fwd_sel_e    i_fwd_b,
    input  logic [`MIPS_XLEN-1:0] i_mem_alu_result,
    input  logic [`MIPS_XLEN-1:0] i_wb_data,
    output mips_pkg::ex_mem_t     o_ex_mem
);

    logic [`MIPS_XLEN-1:0] op_a;
    logic [`MIPS_XLEN-1:0] fwd_b_data;
    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic                  lt_signed;

    // ------------------------------
    // Operand select
    // ------------------------------
    function automatic logic [`MIPS_XLEN-1:0] fwd_mux(
        input mips_pkg::fwd_sel_e    sel,
        input logic [`MIPS_XLEN-1:0] reg_value
    );
        logic [`MIPS_XLEN-1:0] value;
        case (sel)
            mips_pkg::FWD_MEM: value = i_mem_alu_result;
            mips_pkg::FWD_WB:  value = i_wb_data;
            default:           value = reg_value;
        endcase
        return value;
    endfunction

    always_comb begin
        op_a       = fwd_mux(i_fwd_a, i_id_ex.rs_data);
        fwd_b_data = fwd_mux(i_fwd_b, i_id_ex.rt_data);
        op_b       = i_id_ex.ex.alu_src_imm ? i_id_ex.imm : fwd_b_data;
    end

    // ------------------------------
    // ALU
    // ------------------------------
    assign lt_signed = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (i_id_ex.ex.alu_op)
            mips_pkg::ALU_ADD: alu_result = op_a + op_b;
            mips_pkg::ALU_SUB: alu_result = op_a - op_b;
            mips_pkg::ALU_AND: alu_result = op_a & op_b;
            mips_pkg::ALU_OR:  alu_result = op_a | op_b;
            mips_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            mips_pkg::ALU_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
            default:           alu_result = '0;
        endcase
    end

    always_comb begin
        // Word offset from the address after the branch
        o_ex_mem.branch_target = i_id_ex.pc_next + {i_id_ex.imm[`MIPS_XLEN-3:0], 2'b00};
        o_ex_mem.alu_result    = alu_result;
        o_ex_mem.zero          = (alu_result == '0);
        o_ex_mem.store_data    = fwd_b_data;
        o_ex_mem.rd            = i_id_ex.rd;
        o_ex_mem.wb            = i_id_ex.wb;
        o_ex_mem.mem           = i_id_ex.mem;
    end

endmodule

// File: forwarding_unit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module forwarding_unit (
    input  logic [`MIPS_REG_ADDR_W-1:0] i_rs,
    input  logic [`MIPS_REG_ADDR_W-1:0] i_rt,
    input  logic [`MIPS_REG_ADDR_W-1:0] i_mem_rd,
    input  logic                        i_mem_reg_write,
    input  logic [`MIPS_REG_ADDR_W-1:0] i_wb_rd,
    input  logic                        i_wb_reg_write,
    output mips_pkg::fwd_sel_e          o_fwd_a,
    output mips_pkg::fwd_sel_e          o_fwd_b
);

    // Youngest producer first
    // r0 is never forwarded
    function automatic mips_pkg::fwd_sel_e pick_source(
        input logic [`MIPS_REG_ADDR_W-1:0] src
    );
        mips_pkg::fwd_sel_e sel;
        if (i_mem_reg_write && i_mem_rd != '0 && i_mem_rd == src) begin
            sel = mips_pkg::FWD_MEM;
        end else if (i_wb_reg_write && i_wb_rd != '0 && i_wb_rd == src) begin
            sel = mips_pkg::FWD_WB;
        end else begin
            sel = mips_pkg::FWD_NONE;
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd_a = pick_source(i_rs);
        o_fwd_b = pick_source(i_rt);
    end

endmodule

// File: instruction_decode.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module instruction_decode (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic [`MIPS_XLEN-1:0]       i_instr,
    input  logic [`MIPS_XLEN-1:0]       i_pc_next,
    input  logic                        i_wb_we,
    input  logic [`MIPS_REG_ADDR_W-1:0] i_wb_reg,
    input  logic [`MIPS_XLEN-1:0]       i_wb_data,
    input  logic                        i_ex_mem_read,
    input  logic [`MIPS_REG_ADDR_W-1:0] i_ex_rt,
    output mips_pkg::id_ex_t            o_id_ex,
    output logic                        o_stall
);

    localparam int NUM_REGS = 1 << `MIPS_REG_ADDR_W;

    logic [`MIPS_XLEN-1:0]       regs [NUM_REGS];
    mips_pkg::opcode_e           opcode;
    mips_pkg::funct_e            funct;
    logic [`MIPS_REG_ADDR_W-1:0] rs;
    logic [`MIPS_REG_ADDR_W-1:0] rt;
    logic [`MIPS_REG_ADDR_W-1:0] rd;
    mips_pkg::wb_ctrl_t          wb_ctrl;
    mips_pkg::mem_ctrl_t         mem_ctrl;
    mips_pkg::ex_ctrl_t          ex_ctrl;
    logic                        dest_is_rd;

    assign opcode = mips_pkg::opcode_e'(i_instr[31:26]);
    assign funct  = mips_pkg::funct_e'(i_instr[5:0]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_we && i_wb_reg != '0) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    // r0 is hardwired, a write in the same cycle is passed through
    function automatic logic [`MIPS_XLEN-1:0] read_reg(
        input logic [`MIPS_REG_ADDR_W-1:0] addr
    );
        logic [`MIPS_XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (i_wb_we && i_wb_reg == addr) begin
            value = i_wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        wb_ctrl    = '0;
        mem_ctrl   = '0;
        ex_ctrl    = '0;
        dest_is_rd = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dest_is_rd        = 1'b1;
                wb_ctrl.reg_write = 1'b1;
                case (funct)
                    mips_pkg::F_ADDU: ex_ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUBU: ex_ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND:  ex_ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:   ex_ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::F_XOR:  ex_ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::F_SLT:  ex_ctrl.alu_op = mips_pkg::ALU_SLT;
                    // Unknown function code becomes a no-op
                    default:          wb_ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                wb_ctrl.reg_write   = 1'b1;
                ex_ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_LW: begin
                wb_ctrl.reg_write   = 1'b1;
                wb_ctrl.mem_to_reg  = 1'b1;
                mem_ctrl.mem_read   = 1'b1;
                ex_ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_SW: begin
                mem_ctrl.mem_write  = 1'b1;
                ex_ctrl.alu_src_imm = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                mem_ctrl.branch = 1'b1;
                ex_ctrl.alu_op  = mips_pkg::ALU_SUB;
            end
            default: ;
        endcase
    end

    // Load in EX feeding this instruction, hold one cycle
    assign o_stall = i_ex_mem_read && (i_ex_rt != '0) && (i_ex_rt == rs || i_ex_rt == rt);

    always_comb begin
        o_id_ex         = '0;
        o_id_ex.pc_next = i_pc_next;
        o_id_ex.rs_data = read_reg(rs);
        o_id_ex.rt_data = read_reg(rt);
        o_id_ex.imm     = {{(`MIPS_XLEN-16){i_instr[15]}}, i_instr[15:0]};
        o_id_ex.rs      = rs;
        o_id_ex.rt      = rt;
        o_id_ex.rd      = dest_is_rd ? rd : rt;
        o_id_ex.wb      = wb_ctrl;
        o_id_ex.mem     = mem_ctrl;
        o_id_ex.ex      = ex_ctrl;
    end

endmodule

// File: instruction_fetch.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module instruction_fetch (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_stall,
    input  logic                         i_branch_taken,
    input  logic [`MIPS_XLEN-1:0]        i_branch_target,
    input  logic                         i_prog_we,
    input  logic [`MIPS_IMEM_ADDR_W-1:0] i_prog_addr,
    input  logic [`MIPS_XLEN-1:0]        i_prog_data,
    output logic [`MIPS_XLEN-1:0]        o_instr,
    output logic [`MIPS_XLEN-1:0]        o_pc_next
);

    logic [`MIPS_XLEN-1:0]        imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_XLEN-1:0]        pc;
    logic [`MIPS_IMEM_ADDR_W-1:0] pc_word;

    // Program load port, usable while the core sits in reset
    always_ff @(posedge i_clk) begin
        if (i_prog_we) begin
            imem[i_prog_addr] <= i_prog_data;
        end
    end

    // Branch redirect wins over a load-use hold
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc <= `MIPS_RESET_PC;
        end else if (i_branch_taken) begin
            pc <= i_branch_target;
        end else if (!i_stall) begin
            pc <= o_pc_next;
        end
    end

    // Word index, byte offset bits dropped
    assign pc_word   = pc[`MIPS_IMEM_ADDR_W+1:2];
    assign o_instr   = imem[pc_word];
    assign o_pc_next = pc + `MIPS_XLEN'd4;

endmodule

// File: memory_access.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module memory_access (
    input  logic                  i_clk,
    input  mips_pkg::ex_mem_t     i_ex_mem,
    output mips_pkg::mem_wb_t     o_mem_wb,
    output logic                  o_branch_taken,
    output logic [`MIPS_XLEN-1:0] o_branch_target
);

    logic [`MIPS_XLEN-1:0]        dmem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_DMEM_ADDR_W-1:0] word_addr;

    // Whole words only, low address bits ignored
    assign word_addr = i_ex_mem.alu_result[`MIPS_DMEM_ADDR_W+1:2];

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.mem.mem_write) begin
            dmem[word_addr] <= i_ex_mem.store_data;
        end
    end

    always_comb begin
        o_mem_wb.load_data  = dmem[word_addr];
        o_mem_wb.alu_result = i_ex_mem.alu_result;
        o_mem_wb.rd         = i_ex_mem.rd;
        o_mem_wb.wb         = i_ex_mem.wb;
    end

    // BEQ resolves here, operands compared by subtraction in EX
    assign o_branch_taken  = i_ex_mem.mem.branch && i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.branch_target;

endmodule

// File: mips_assert.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_assert (
    input logic                        i_clk,
    input logic                        i_rst,
    input logic                        i_wb_en,
    input logic [`MIPS_REG_ADDR_W-1:0] i_wb_reg,
    input logic                        i_stall,
    input logic                        i_branch_taken,
    input logic [`MIPS_XLEN-1:0]       i_pc_next,
    input mips_pkg::ex_mem_t           i_ex_mem
);

    // ------------------------------
    // Write-back port
    // ------------------------------
    // Quiet once reset has been seen on an edge
    assert property (@(posedge i_clk) (!i_rst && !$past(i_rst)) |-> !i_wb_en)
        else $error("register write reported while the core is held in reset");

    assert property (@(posedge i_clk) i_wb_en |-> (i_wb_reg != '0))
        else $error("register write reported for r0");

    // ------------------------------
    // Stall and flush
    // ------------------------------
    // PC+4 only moves when the PC moves
    assert property (@(posedge i_clk) disable iff (!i_rst)
        (i_stall && !i_branch_taken) |=> $stable(i_pc_next))
        else $error("PC changed during a load-use stall");

    assert property (@(posedge i_clk) disable iff (!i_rst)
        i_branch_taken |=> (i_ex_mem.wb == '0 && i_ex_mem.mem == '0))
        else $error("EX/MEM control not cleared after a taken branch");

endmodule

// File: mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// ------------------------------
// Datapath widths
// ------------------------------
// Data and instruction word
`define MIPS_XLEN 32
// Register number, 32 registers
`define MIPS_REG_ADDR_W 5

// ------------------------------
// Memories
// ------------------------------
// Program memory, in 32-bit words
`define MIPS_IMEM_DEPTH 256
`define MIPS_IMEM_ADDR_W 8
// Data memory, in 32-bit words
`define MIPS_DMEM_DEPTH 256
`define MIPS_DMEM_ADDR_W 8

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: mips_pkg.sv
`include "mips_macros.svh"

package mips_pkg;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_BEQ   = 6'd4,
        OP_ADDIU = 6'd9,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADDU = 6'd33,
        F_SUBU = 6'd35,
        F_AND  = 6'd36,
        F_OR   = 6'd37,
        F_XOR  = 6'd38,
        F_SLT  = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    // ------------------------------
    // Control groups
    // ------------------------------
    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } wb_ctrl_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic branch;
    } mem_ctrl_t;

    typedef struct packed {
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ex_ctrl_t;

    // ------------------------------
    // Pipeline registers
    // ------------------------------
    typedef struct packed {
        logic [`MIPS_XLEN-1:0]       pc_next;
        logic [`MIPS_XLEN-1:0]       rs_data;
        logic [`MIPS_XLEN-1:0]       rt_data;
        logic [`MIPS_XLEN-1:0]       imm;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        // Destination, rt or rd already chosen
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        wb_ctrl_t                    wb;
        mem_ctrl_t                   mem;
        ex_ctrl_t                    ex;
    } id_ex_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]       branch_target;
        logic [`MIPS_XLEN-1:0]       alu_result;
        logic                        zero;
        logic [`MIPS_XLEN-1:0]       store_data;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        wb_ctrl_t                    wb;
        mem_ctrl_t                   mem;
    } ex_mem_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]       load_data;
        logic [`MIPS_XLEN-1:0]       alu_result;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        wb_ctrl_t                    wb;
    } mem_wb_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the MIPS pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_top_mips -o tb_top_mips
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_top_mips > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: src.f
+incdir+.
mips_pkg.sv
instruction_fetch.sv
instruction_decode.sv
forwarding_unit.sv
execute.sv
memory_access.sv
top_mips.sv
tb_clock_gen.sv
mips_assert.sv
tb_top_mips.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    // Starts low, first rising edge after half a period
    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: tb_top_mips.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_top_mips;

    localparam int CLK_PERIOD_NS   = 100;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 300;
    localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD_NS;
    // Cycles allowed for the expected writes to appear
    localparam int RUN_LIMIT       = 200;
    localparam int SEED            = 70194;

    logic                         clk;
    logic                         rst;
    logic                         prog_we;
    logic [`MIPS_IMEM_ADDR_W-1:0] prog_addr;
    logic [`MIPS_XLEN-1:0]        prog_data;
    logic                         wb_en;
    logic [`MIPS_REG_ADDR_W-1:0]  wb_reg;
    logic [`MIPS_XLEN-1:0]        wb_data;

    logic [`MIPS_XLEN-1:0]        prog [$];
    logic [`MIPS_REG_ADDR_W-1:0]  exp_reg [$];
    logic [`MIPS_XLEN-1:0]        exp_val [$];
    // Data memory contents as seen by the model, kept across tests like the DUT
    logic [`MIPS_XLEN-1:0]        model_mem [int];
    int                           errors = 0;
    int                           checks = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock_gen (.o_clk(clk));

    top_mips DUT (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_prog_we   (prog_we),
        .i_prog_addr (prog_addr),
        .i_prog_data (prog_data),
        .o_wb_en     (wb_en),
        .o_wb_reg    (wb_reg),
        .o_wb_data   (wb_data)
    );

    bind top_mips mips_assert u_mips_assert (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_wb_en        (o_wb_en),
        .i_wb_reg       (o_wb_reg),
        .i_stall        (stall),
        .i_branch_taken (branch_taken),
        .i_pc_next      (if_pc_next),
        .i_ex_mem       (ex_mem_q)
    );

    // ------------------------------
    // Instruction encoding
    // ------------------------------
    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {6'd0, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rand_imm();
        return 16'($urandom());
    endfunction

    task automatic append(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // Self-looping BEQ, then a few NOPs so stale words never get fetched
    task automatic close_program();
        append(itype_word(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hFFFF));
        repeat (4) append(32'd0);
    endtask

    // ------------------------------
    // Golden model, one instruction at a time
    // ------------------------------
    task automatic golden_model();
        logic [31:0] regs [32];
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [4:0]  dst;
        int          pc;
        int          steps;
        int          key;
        bit          wr;
        bit          halted;
        exp_reg.delete();
        exp_val.delete();
        foreach (regs[i]) regs[i] = '0;
        pc     = 0;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < 1000) begin
            ins   = (pc < prog.size()) ? prog[pc] : 32'd0;
            a     = regs[ins[25:21]];
            b     = regs[ins[20:16]];
            imm   = {{16{ins[15]}}, ins[15:0]};
            key   = int'((a + imm) >> 2) & (`MIPS_DMEM_DEPTH - 1);
            dst   = ins[20:16];
            res   = '0;
            wr    = 1'b0;
            pc    = pc + 1;
            steps = steps + 1;
            case (ins[31:26])
                mips_pkg::OP_RTYPE: begin
                    wr  = 1'b1;
                    dst = ins[15:11];
                    case (ins[5:0])
                        mips_pkg::F_ADDU: res = a + b;
                        mips_pkg::F_SUBU: res = a - b;
                        mips_pkg::F_AND:  res = a & b;
                        mips_pkg::F_OR:   res = a | b;
                        mips_pkg::F_XOR:  res = a ^ b;
                        mips_pkg::F_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr = 1'b0;
                    endcase
                end
                mips_pkg::OP_ADDIU: begin
                    wr  = 1'b1;
                    res = a + imm;
                end
                mips_pkg::OP_LW: begin
                    wr  = 1'b1;
                    res = model_mem.exists(key) ? model_mem[key] : 32'd0;
                end
                mips_pkg::OP_SW: model_mem[key] = b;
                mips_pkg::OP_BEQ: begin
                    // Offset counts words from the following instruction
                    if (a == b && imm == 32'hFFFF_FFFF) begin
                        halted = 1'b1;
                    end else if (a == b) begin
                        pc = pc + int'($signed(imm));
                    end
                end
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_reg.push_back(dst);
                exp_val.push_back(res);
            end
        end
    endtask

    // ------------------------------
    // DUT drive and compare
    // ------------------------------
    task automatic compare_write(input string name, input int idx);
        checks++;
        assert (idx < exp_reg.size()) else begin
            errors++;
            $display("ERROR: %s reported an extra write to r%0d", name, wb_reg);
        end
        if (idx < exp_reg.size()) begin
            assert (wb_reg == exp_reg[idx]) else begin
                errors++;
                $display("MISMATCH o_wb_reg (%s, write %0d): got 0x%h expected 0x%h",
                         name, idx, wb_reg, exp_reg[idx]);
            end
            assert (wb_data == exp_val[idx]) else begin
                errors++;
                $display("MISMATCH o_wb_data (%s, write %0d): got 0x%h expected 0x%h",
                         name, idx, wb_data, exp_val[idx]);
            end
        end
    endtask

    task automatic run_program(input string name);
        int got;
        int cycles;
        golden_model();
        @(negedge clk);
        rst = 1'b0;
        repeat (8) @(negedge clk);
        // Program goes in while the core is still held in reset
        foreach (prog[i]) begin
            prog_we   = 1'b1;
            prog_addr = `MIPS_IMEM_ADDR_W'(i);
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        rst     = 1'b1;
        got     = 0;
        cycles  = 0;
        while (got < exp_reg.size() && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (wb_en) begin
                compare_write(name, got);
                got++;
            end
        end
        // Watch a while longer for writes that should not happen
        repeat (20) begin
            @(negedge clk);
            if (wb_en) begin
                compare_write(name, got);
                got++;
            end
        end
        checks++;
        assert (got == exp_reg.size()) else begin
            errors++;
            $display("ERROR: %s expected %0d register writes but saw %0d",
                     name, exp_reg.size(), got);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic alu_ops_test();
        prog.delete();
        for (int r = 1; r <= 4; r++) begin
            append(itype_word(mips_pkg::OP_ADDIU, 5'(r), 5'd0, rand_imm()));
        end
        append(rtype_word(mips_pkg::F_ADDU, 5'd5, 5'd1, 5'd2));
        append(rtype_word(mips_pkg::F_SUBU, 5'd6, 5'd3, 5'd4));
        append(rtype_word(mips_pkg::F_AND, 5'd7, 5'd1, 5'd3));
        append(rtype_word(mips_pkg::F_OR, 5'd8, 5'd2, 5'd4));
        append(rtype_word(mips_pkg::F_XOR, 5'd9, 5'd1, 5'd4));
        append(rtype_word(mips_pkg::F_SLT, 5'd10, 5'd2, 5'd3));
        close_program();
        run_program("alu_ops");
    endtask

    task automatic forwarding_test();
        prog.delete();
        append(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, rand_imm()));
        append(rtype_word(mips_pkg::F_ADDU, 5'd2, 5'd1, 5'd1));
        append(rtype_word(mips_pkg::F_SUBU, 5'd3, 5'd2, 5'd1));
        append(rtype_word(mips_pkg::F_XOR, 5'd4, 5'd3, 5'd2));
        append(rtype_word(mips_pkg::F_AND, 5'd5, 5'd4, 5'd3));
        append(rtype_word(mips_pkg::F_OR, 5'd6, 5'd5, 5'd1));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd7, 5'd6, rand_imm()));
        append(rtype_word(mips_pkg::F_SLT, 5'd8, 5'd7, 5'd5));
        close_program();
        run_program("forwarding");
    endtask

    task automatic load_use_test();
        prog.delete();
        append(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0040));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd2, 5'd0, rand_imm()));
        append(itype_word(mips_pkg::OP_SW, 5'd2, 5'd1, 16'h0000));
        append(itype_word(mips_pkg::OP_LW, 5'd3, 5'd1, 16'h0000));
        append(rtype_word(mips_pkg::F_ADDU, 5'd4, 5'd3, 5'd2));
        append(itype_word(mips_pkg::OP_SW, 5'd4, 5'd1, 16'h0008));
        append(itype_word(mips_pkg::OP_LW, 5'd5, 5'd1, 16'h0008));
        // Loaded value used right away as store data
        append(itype_word(mips_pkg::OP_SW, 5'd5, 5'd1, 16'h000C));
        append(itype_word(mips_pkg::OP_LW, 5'd6, 5'd1, 16'h000C));
        append(rtype_word(mips_pkg::F_SUBU, 5'd7, 5'd6, 5'd3));
        close_program();
        run_program("load_use");
    endtask

    task automatic branch_test();
        logic [15:0] same;
        same = rand_imm();
        prog.delete();
        append(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, same));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd2, 5'd0, same));
        // Taken, skips the next three
        append(itype_word(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd3));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd3, 5'd0, rand_imm()));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd4, 5'd0, rand_imm()));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd5, 5'd0, rand_imm()));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd6, 5'd1, rand_imm()));
        // Not taken, r1 is never zero here
        append(itype_word(mips_pkg::OP_BEQ, 5'd0, 5'd1, 16'd5));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd7, 5'd0, rand_imm()));
        append(rtype_word(mips_pkg::F_ADDU, 5'd8, 5'd7, 5'd6));
        append(rtype_word(mips_pkg::F_XOR, 5'd9, 5'd8, 5'd1));
        close_program();
        // Guard against a random value of zero making the second BEQ taken
        if (same == 16'd0) begin
            prog[0] = itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd1);
            prog[1] = itype_word(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd1);
        end
        run_program("branch");
    endtask

    task automatic zero_reg_test();
        prog.delete();
        append(itype_word(mips_pkg::OP_ADDIU, 5'd0, 5'd0, rand_imm()));
        append(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, rand_imm()));
        append(rtype_word(mips_pkg::F_ADDU, 5'd0, 5'd1, 5'd1));
        append(rtype_word(mips_pkg::F_OR, 5'd2, 5'd0, 5'd1));
        append(rtype_word(mips_pkg::F_ADDU, 5'd3, 5'd0, 5'd0));
        append(rtype_word(mips_pkg::F_SLT, 5'd4, 5'd0, 5'd1));
        append(rtype_word(mips_pkg::F_SUBU, 5'd5, 5'd0, 5'd1));
        close_program();
        run_program("zero_reg");
    endtask

    // ------------------------------
    // Sequence and end of run
    // ------------------------------
    initial begin
        rst       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(SEED));
        alu_ops_test();
        forwarding_test();
        load_use_test();
        branch_test();
        zero_reg_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run did not complete within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: top_mips.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module top_mips (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_prog_we,
    input  logic [`MIPS_IMEM_ADDR_W-1:0] i_prog_addr,
    input  logic [`MIPS_XLEN-1:0]        i_prog_data,
    output logic                         o_wb_en,
    output logic [`MIPS_REG_ADDR_W-1:0]  o_wb_reg,
    output logic [`MIPS_XLEN-1:0]        o_wb_data
);

    logic [`MIPS_XLEN-1:0] if_instr;
    logic [`MIPS_XLEN-1:0] if_pc_next;
    logic [`MIPS_XLEN-1:0] if_id_instr;
    logic [`MIPS_XLEN-1:0] if_id_pc_next;
    mips_pkg::id_ex_t      id_ex_d;
    mips_pkg::id_ex_t      id_ex_q;
    mips_pkg::ex_mem_t     ex_mem_d;
    mips_pkg::ex_mem_t     ex_mem_q;
    mips_pkg::mem_wb_t     mem_wb_d;
    mips_pkg::mem_wb_t     mem_wb_q;
    mips_pkg::fwd_sel_e    fwd_a;
    mips_pkg::fwd_sel_e    fwd_b;
    logic                  stall;
    logic                  branch_taken;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] wb_data;
    logic                  wb_en;

    // ------------------------------
    // Pipeline registers
    // ------------------------------
    // Flush beats stall, IF/ID cleared to an all-zero no-op
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            if_id_instr   <= '0;
            if_id_pc_next <= '0;
            id_ex_q       <= '0;
            ex_mem_q      <= '0;
            mem_wb_q      <= '0;
        end else begin
            if (branch_taken) begin
                if_id_instr   <= '0;
                if_id_pc_next <= '0;
            end else if (!stall) begin
                if_id_instr   <= if_instr;
                if_id_pc_next <= if_pc_next;
            end

            id_ex_q <= id_ex_d;
            // Bubble on load-use or flush
            if (branch_taken || stall) begin
                id_ex_q.wb  <= '0;
                id_ex_q.mem <= '0;
                id_ex_q.ex  <= '0;
            end

            ex_mem_q <= ex_mem_d;
            if (branch_taken) begin
                ex_mem_q.wb  <= '0;
                ex_mem_q.mem <= '0;
            end

            mem_wb_q <= mem_wb_d;
        end
    end

    // ------------------------------
    // Write-back select
    // ------------------------------
    assign wb_data = mem_wb_q.wb.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
    assign wb_en   = mem_wb_q.wb.reg_write && (mem_wb_q.rd != '0);

    assign o_wb_en   = wb_en;
    assign o_wb_reg  = mem_wb_q.rd;
    assign o_wb_data = wb_data;

    // ------------------------------
    // Stages
    // ------------------------------
    instruction_fetch u_instruction_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_stall         (stall),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_prog_we       (i_prog_we),
        .i_prog_addr     (i_prog_addr),
        .i_prog_data     (i_prog_data),
        .o_instr         (if_instr),
        .o_pc_next       (if_pc_next)
    );

    instruction_decode u_instruction_decode (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr       (if_id_instr),
        .i_pc_next     (if_id_pc_next),
        .i_wb_we       (wb_en),
        .i_wb_reg      (mem_wb_q.rd),
        .i_wb_data     (wb_data),
        .i_ex_mem_read (id_ex_q.mem.mem_read),
        .i_ex_rt       (id_ex_q.rt),
        .o_id_ex       (id_ex_d),
        .o_stall       (stall)
    );

    forwarding_unit u_forwarding_unit (
        .i_rs            (id_ex_q.rs),
        .i_rt            (id_ex_q.rt),
        .i_mem_rd        (ex_mem_q.rd),
        .i_mem_reg_write (ex_mem_q.wb.reg_write),
        .i_wb_rd         (mem_wb_q.rd),
        .i_wb_reg_write  (mem_wb_q.wb.reg_write),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b)
    );

    execute u_execute (
        .i_id_ex          (id_ex_q),
        .i_fwd_a          (fwd_a),
        .i_fwd_b          (fwd_b),
        .i_mem_alu_result (ex_mem_q.alu_result),
        .i_wb_data        (wb_data),
        .o_ex_mem         (ex_mem_d)
    );

    memory_access u_memory_access (
        .i_clk           (i_clk),
        .i_ex_mem        (ex_mem_q),
        .o_mem_wb        (mem_wb_d),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

endmodule
